// File: rv32_core.f
+incdir+src
src/rv32_isa_pkg.sv
src/rv32_core_pkg.sv
src/rv32_word_ram.sv
src/rv32_regfile.sv
src/rv32_decoder.sv
src/rv32_alu.sv
src/rv32_host_ctrl.sv
src/rv32_core.sv
test/rv32_core_tb.sv

// File: Makefile
TOP = rv32_core_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f rv32_core.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f rv32_core.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then exit 1; fi
	@if ! grep -qF '*** TEST PASSED ***' $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: test/rv32_core_tb.sv
`timescale 1ns/1ps

`include "rv32_params.svh"

module rv32_core_tb;

    import rv32_isa_pkg::*;
    import rv32_core_pkg::*;

    localparam int NUM_ROWS = 21;
    // table rows plus the reset scan and the two program tests
    localparam int CYCLE_LIMIT = 200 * (NUM_ROWS + 3);
    // longest run before the pc wraps around the program memory
    localparam int RUN_LIMIT = `RV32_IMEM_WORDS + 2;

    typedef struct packed {
        logic [63:0]                  name;
        word_t                        instr;
        word_t                        x1_val;
        word_t                        x2_val;
        logic                         mem_en;
        logic [`RV32_WORD_ADDR_W-1:0] mem_idx;
        word_t                        mem_val;
        logic                         read_mem;
        logic [`RV32_WORD_ADDR_W-1:0] read_idx;
        word_t                        expected;
    } row_t;

    logic      clk;
    logic      arst_n;
    logic      host_req;
    host_cmd_t host_cmd;
    logic      host_ack;
    word_t     host_rdata;
    logic      halted;

    row_t rows [NUM_ROWS];
    int   num_checks;
    int   num_errors;
    int   cycles;

    rv32_core rv32_core_i (
        .clk(clk), .arst_n(arst_n), .host_req(host_req), .host_cmd(host_cmd),
        .host_ack(host_ack), .host_rdata(host_rdata), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the DUT stopped answering", cycles);
        $display("checks %0d, errors %0d", num_checks, num_errors + 1);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic check(input string name, input word_t expected, input word_t actual);
        num_checks++;
        if (actual !== expected) begin
            num_errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // four-phase req/ack started 1 ns after a rising edge
    task automatic handshake(input host_op_t op, input logic [4:0] addr, input word_t wdata,
                             output word_t rdata, output int waited,
                             output logic ack_halted);
        host_cmd.op    = op;
        host_cmd.addr  = addr;
        host_cmd.wdata = wdata;
        host_req       = 1'b1;
        waited         = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!host_ack);
        rdata      = host_rdata;
        ack_halted = halted;
        host_req   = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (host_ack);
    endtask

    task automatic poke(input host_op_t op, input logic [4:0] addr, input word_t wdata);
        word_t unused_rdata;
        int    unused_wait;
        logic  unused_halted;
        handshake(op, addr, wdata, unused_rdata, unused_wait, unused_halted);
    endtask

    task automatic peek(input host_op_t op, input logic [4:0] addr, output word_t rdata);
        int   unused_wait;
        logic unused_halted;
        handshake(op, addr, '0, rdata, unused_wait, unused_halted);
    endtask

    // gives up after max_cycles so that a core that never halts is caught
    task automatic wait_halted(input int max_cycles);
        int n;
        n = 0;
        while (!halted && n < max_cycles) begin
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t sign_extend(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // x1 and x2 preset and the result read from x3
    function automatic row_t make_row(input logic [63:0] name, input word_t instr,
                                      input word_t a, input word_t b, input word_t expected);
        row_t r;
        r          = '0;
        r.name     = name;
        r.instr    = instr;
        r.x1_val   = a;
        r.x2_val   = b;
        r.read_idx = 5'd3;
        r.expected = expected;
        return r;
    endfunction

    task automatic build_table();
        word_t       a;
        word_t       b;
        word_t       n;
        word_t       base;
        logic [11:0] imm;
        logic [11:0] imm_neg;
        logic [11:0] off;
        logic [4:0]  sh;
        logic [19:0] up;
        a       = $urandom;
        b       = $urandom;
        n       = $urandom | 32'h8000_0000;
        imm     = 12'($urandom);
        imm_neg = 12'($urandom) | 12'h800;
        sh      = 5'($urandom);
        up      = 20'($urandom);
        rows[0]  = make_row("add", r_type(7'h00, 2, 1, F3_ADD_SUB, 3), a, b, a + b);
        rows[1]  = make_row("sub", r_type(7'h20, 2, 1, F3_ADD_SUB, 3), a, b, a - b);
        rows[2]  = make_row("sll", r_type(7'h00, 2, 1, F3_SLL, 3), a, b, a << b[4:0]);
        rows[3]  = make_row("slt_neg", r_type(7'h00, 2, 1, F3_SLT, 3), n, b >> 1,
                            {31'b0, $signed(n) < $signed(b >> 1)});
        rows[4]  = make_row("slt_pos", r_type(7'h00, 2, 1, F3_SLT, 3), b >> 1, n,
                            {31'b0, $signed(b >> 1) < $signed(n)});
        rows[5]  = make_row("xor", r_type(7'h00, 2, 1, F3_XOR, 3), a, b, a ^ b);
        rows[6]  = make_row("srl", r_type(7'h00, 2, 1, F3_SRL_SRA, 3), a, b, a >> b[4:0]);
        rows[7]  = make_row("sra", r_type(7'h20, 2, 1, F3_SRL_SRA, 3), n, b,
                            word_t'($signed(n) >>> b[4:0]));
        rows[8]  = make_row("or", r_type(7'h00, 2, 1, F3_OR, 3), a, b, a | b);
        rows[9]  = make_row("and", r_type(7'h00, 2, 1, F3_AND, 3), a, b, a & b);
        rows[10] = make_row("addi_neg", i_type(imm_neg, 1, F3_ADD_SUB, 3, OPC_OP_IMM), a, 0,
                            a + sign_extend(imm_neg));
        rows[11] = make_row("slti", i_type(imm, 1, F3_SLT, 3, OPC_OP_IMM), n, 0,
                            {31'b0, $signed(n) < $signed(sign_extend(imm))});
        rows[12] = make_row("xori", i_type(imm, 1, F3_XOR, 3, OPC_OP_IMM), a, 0,
                            a ^ sign_extend(imm));
        rows[13] = make_row("ori", i_type(imm, 1, F3_OR, 3, OPC_OP_IMM), a, 0,
                            a | sign_extend(imm));
        rows[14] = make_row("andi", i_type(imm, 1, F3_AND, 3, OPC_OP_IMM), a, 0,
                            a & sign_extend(imm));
        rows[15] = make_row("slli", i_type({7'h00, sh}, 1, F3_SLL, 3, OPC_OP_IMM), a, 0, a << sh);
        rows[16] = make_row("srli", i_type({7'h00, sh}, 1, F3_SRL_SRA, 3, OPC_OP_IMM), a, 0,
                            a >> sh);
        rows[17] = make_row("srai", i_type({7'h20, sh}, 1, F3_SRL_SRA, 3, OPC_OP_IMM), n, 0,
                            word_t'($signed(n) >>> sh));
        rows[18] = make_row("lui", {up, 5'd3, OPC_LUI}, 0, 0, word_t'(up) << 12);
        base = 4 * ($urandom % 16);
        off  = 12'(4 * ($urandom % 16));
        rows[19] = make_row("sw", s_type(off, 2, 1), base, b, b);
        rows[19].read_mem = 1'b1;
        rows[19].read_idx = 5'((base + sign_extend(off)) / 4);
        // negative offset from a base in the upper half
        base = 64 + 4 * ($urandom % 16);
        off  = 12'(0) - 12'(4 * ($urandom % 16));
        rows[20] = make_row("lw", i_type(off, 1, 3'b010, 3, OPC_LOAD), base, 0, a);
        rows[20].mem_en  = 1'b1;
        rows[20].mem_idx = 5'((base + sign_extend(off)) / 4);
        rows[20].mem_val = a;
    endtask

    task automatic apply_row(input row_t r);
        word_t got;
        poke(HOST_WRITE_REG, 5'd1, r.x1_val);
        poke(HOST_WRITE_REG, 5'd2, r.x2_val);
        // stale results must not match
        if (r.read_mem)
            poke(HOST_WRITE_MEM, r.read_idx, ~r.expected);
        else
            poke(HOST_WRITE_REG, r.read_idx, ~r.expected);
        if (r.mem_en)
            poke(HOST_WRITE_MEM, r.mem_idx, r.mem_val);
        poke(HOST_LOAD_IMEM, 5'd0, r.instr);
        poke(HOST_LOAD_IMEM, 5'd1, '0);
        poke(HOST_START, 5'd0, '0);
        wait_halted(RUN_LIMIT);
        if (r.read_mem)
            peek(HOST_READ_MEM, r.read_idx, got);
        else
            peek(HOST_READ_REG, r.read_idx, got);
        check($sformatf("%s", r.name), r.expected, got);
    endtask

    task automatic three_instr_program();
        word_t a;
        word_t b;
        word_t got;
        a = $urandom;
        b = $urandom;
        poke(HOST_WRITE_REG, 5'd1, a);
        poke(HOST_WRITE_REG, 5'd2, b);
        poke(HOST_WRITE_REG, 5'd4, ~b);
        poke(HOST_LOAD_IMEM, 5'd0, r_type(7'h00, 2, 1, F3_ADD_SUB, 3));
        poke(HOST_LOAD_IMEM, 5'd1, r_type(7'h20, 1, 3, F3_ADD_SUB, 4));
        poke(HOST_LOAD_IMEM, 5'd2, i_type(12'd5, 4, F3_ADD_SUB, 0, OPC_OP_IMM));
        poke(HOST_LOAD_IMEM, 5'd3, '0);
        poke(HOST_START, 5'd0, '0);
        wait_halted(RUN_LIMIT);
        check("prog halted", 1, word_t'(halted));
        peek(HOST_READ_REG, 5'd4, got);
        check("prog sub", (a + b) - a, got);
        peek(HOST_READ_REG, 5'd0, got);
        check("prog x0", 0, got);
    endtask

    task automatic read_while_running();
        word_t v;
        word_t got;
        int    waited;
        logic  ack_halted;
        v = $urandom;
        poke(HOST_WRITE_REG, 5'd6, v);
        for (int i = 0; i < 4; i++) begin
            poke(HOST_LOAD_IMEM, 5'(i), i_type(12'd3, 6, F3_ADD_SUB, 6, OPC_OP_IMM));
        end
        poke(HOST_LOAD_IMEM, 5'd4, '0);
        poke(HOST_START, 5'd0, '0);
        handshake(HOST_READ_REG, 5'd6, '0, got, waited, ack_halted);
        check("held halted", 1, word_t'(ack_halted));
        check("held wait", 1, word_t'(waited > 1));
        check("held x6", v + 12, got);
    endtask

    initial begin
        word_t got;
        void'($urandom(33));
        num_checks = 0;
        num_errors = 0;
        arst_n     = 1'b0;
        host_req   = 1'b0;
        host_cmd   = '0;
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check("reset halted", 1, word_t'(halted));
        check("reset ack", 0, word_t'(host_ack));
        for (int i = 0; i < `RV32_NUM_REGS; i++) begin
            peek(HOST_READ_REG, 5'(i), got);
            check($sformatf("reset x%0d", i), 0, got);
        end
        build_table();
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(rows[i]);
        end
        three_instr_program();
        read_while_running();
        $display("checks %0d, errors %0d", num_checks, num_errors);
        if (num_errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: src/rv32_core.sv
`timescale 1ns/1ps

`include "rv32_params.svh"

module rv32_core (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      host_req,
    input  rv32_core_pkg::host_cmd_t  host_cmd,
    output logic                      host_ack,
    output rv32_isa_pkg::word_t       host_rdata,
    output logic                      halted
);

    import rv32_isa_pkg::*;
    import rv32_core_pkg::*;

    word_t        pc;
    instr_t       instr;
    ctrl_t        ctrl;
    word_t        imm;
    word_t        rf_rdata1;
    word_t        rf_rdata2;
    word_t        alu_b;
    word_t        alu_result;
    word_t        dmem_rdata;
    word_t        wb_data;
    logic         running;
    host_access_t access;

    logic [`RV32_WORD_ADDR_W-1:0] imem_addr;
    logic [`RV32_WORD_ADDR_W-1:0] dmem_addr;
    reg_idx_t                     rf_rs1;
    reg_idx_t                     rf_rd;
    logic                         rf_we;
    word_t                        rf_wdata;
    logic                         dmem_we;
    word_t                        dmem_wdata;

    assign halted = !running;

    // PC parks at 0 while halted, so START begins at word 0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (running && !ctrl.halt) begin
            pc <= pc + 32'd4;
        end else begin
            pc <= '0;
        end
    end

    // host owns the ports while halted
    assign imem_addr  = running ? pc[`RV32_WORD_ADDR_W+1:2] : access.idx;
    assign dmem_addr  = running ? alu_result[`RV32_WORD_ADDR_W+1:2] : access.idx;
    assign dmem_we    = running ? ctrl.mem_write : access.dmem_we;
    assign dmem_wdata = running ? rf_rdata2 : access.wdata;
    assign rf_rs1     = running ? instr.rs1 : access.idx;
    assign rf_rd      = running ? instr.rd : access.idx;
    assign rf_we      = running ? ctrl.reg_write : access.reg_we;
    assign rf_wdata   = running ? wb_data : access.wdata;

    assign alu_b      = ctrl.use_imm ? imm : rf_rdata2;
    assign wb_data    = ctrl.mem_to_reg ? dmem_rdata : alu_result;
    assign host_rdata = (host_cmd.op == HOST_READ_MEM) ? dmem_rdata : rf_rdata1;

    rv32_word_ram #(.payload_t(instr_t), .DEPTH(`RV32_IMEM_WORDS)) imem (
        .clk(clk), .addr(imem_addr), .we(access.imem_we),
        .wdata(instr_t'(access.wdata)), .rdata(instr)
    );

    rv32_word_ram #(.payload_t(word_t), .DEPTH(`RV32_DMEM_WORDS)) dmem (
        .clk(clk), .addr(dmem_addr), .we(dmem_we),
        .wdata(dmem_wdata), .rdata(dmem_rdata)
    );

    rv32_regfile regfile (
        .clk(clk), .arst_n(arst_n), .rs1(rf_rs1), .rs2(instr.rs2), .rd(rf_rd),
        .we(rf_we), .wdata(rf_wdata), .rdata1(rf_rdata1), .rdata2(rf_rdata2)
    );

    rv32_decoder decoder (.instr(instr), .ctrl(ctrl), .imm(imm));

    rv32_alu alu (.a(rf_rdata1), .b(alu_b), .op(ctrl.alu_op), .result(alu_result));

    rv32_host_ctrl host_ctrl (
        .clk(clk), .arst_n(arst_n), .req(host_req), .cmd(host_cmd),
        .halt_fetch(ctrl.halt), .ack(host_ack), .running(running), .access(access)
    );

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!arst_n)
        pc[1:0] == 2'b00
    ) else $error("pc %h misaligned", pc);

endmodule

// File: src/rv32_host_ctrl.sv
`timescale 1ns/1ps

module rv32_host_ctrl (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         req,
    input  rv32_core_pkg::host_cmd_t     cmd,
    input  logic                         halt_fetch,
    output logic                         ack,
    output logic                         running,
    output rv32_core_pkg::host_access_t  access
);

    import rv32_core_pkg::*;

    logic grant;

    // one grant per request, and only with the core stopped
    assign grant = req && !ack && !running;

    always_comb begin
        access       = '0;
        access.idx   = cmd.addr;
        access.wdata = cmd.wdata;
        if (grant) begin
            case (cmd.op)
                HOST_LOAD_IMEM: access.imem_we = 1'b1;
                HOST_WRITE_REG: access.reg_we  = 1'b1;
                HOST_WRITE_MEM: access.dmem_we = 1'b1;
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack     <= 1'b0;
            running <= 1'b0;
        end else begin
            if (grant) begin
                ack <= 1'b1;
            end else if (!req) begin
                ack <= 1'b0;
            end

            if (grant && cmd.op == HOST_START) begin
                running <= 1'b1;
            end else if (running && halt_fetch) begin
                running <= 1'b0;
            end
        end
    end

    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(ack) |-> $past(req) && !$past(running)
    ) else $error("host ack raised without a pending request");

    a_no_write_running: assert property (
        @(posedge clk) disable iff (!arst_n)
        (access.imem_we || access.reg_we || access.dmem_we) |-> !running
    ) else $error("host write strobe while the core runs");

endmodule

// File: src/rv32_alu.sv
`timescale 1ns/1ps

`include "rv32_params.svh"

module rv32_alu (
    input  rv32_isa_pkg::word_t     a,
    input  rv32_isa_pkg::word_t     b,
    input  rv32_core_pkg::alu_op_t  op,
    output rv32_isa_pkg::word_t     result
);

    import rv32_isa_pkg::*;
    import rv32_core_pkg::*;

    logic [4:0] shamt;
    logic       lt;

    assign shamt = b[4:0];
    assign lt    = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = {{(`RV32_XLEN-1){1'b0}}, lt};
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = word_t'($signed(a) >>> shamt);
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            // lui
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

endmodule

// File: src/rv32_decoder.sv
`timescale 1ns/1ps

module rv32_decoder (
    input  rv32_isa_pkg::instr_t   instr,
    output rv32_core_pkg::ctrl_t   ctrl,
    output rv32_isa_pkg::word_t    imm
);

    import rv32_isa_pkg::*;
    import rv32_core_pkg::*;

    word_t raw;
    word_t imm_i;
    word_t imm_s;
    word_t imm_u;
    logic  alt;

    assign raw = instr;
    assign alt = instr.funct7[FUNCT7_ALT_BIT];

    assign imm_i = {{20{raw[31]}}, raw[31:20]};
    assign imm_s = {{20{raw[31]}}, raw[31:25], raw[11:7]};
    assign imm_u = {raw[31:12], 12'b0};

    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic sel_alt);
        alu_op_t op;
        case (funct3_t'(f3))
            F3_ADD_SUB: op = sel_alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = sel_alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            F3_AND:     op = ALU_AND;
            default:    op = ALU_ADD;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        imm         = imm_i;
        case (opcode_t'(instr.opcode))
            OPC_OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = arith_op(instr.funct3, alt);
            end
            OPC_OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                // funct7 is immediate data except on the right shifts
                ctrl.alu_op    = arith_op(instr.funct3,
                                          alt && instr.funct3 == F3_SRL_SRA);
            end
            OPC_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.alu_op    = ALU_PASS_B;
                imm            = imm_u;
            end
            OPC_LOAD: begin
                ctrl.reg_write  = 1'b1;
                ctrl.use_imm    = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            OPC_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                imm            = imm_s;
            end
            default: begin
            end
        endcase
        // fill word of the program memory ends the run
        ctrl.halt = (raw == '0);
    end

    always_comb begin
        a_one_writer: assert (!(ctrl.reg_write && ctrl.mem_write))
            else $error("decoder enables both register and memory write");
    end

endmodule

// File: src/rv32_regfile.sv
`timescale 1ns/1ps

`include "rv32_params.svh"

module rv32_regfile (
    input  logic                  clk,
    input  logic                  arst_n,
    input  rv32_isa_pkg::reg_idx_t rs1,
    input  rv32_isa_pkg::reg_idx_t rs2,
    input  rv32_isa_pkg::reg_idx_t rd,
    input  logic                  we,
    input  rv32_isa_pkg::word_t    wdata,
    output rv32_isa_pkg::word_t    rdata1,
    output rv32_isa_pkg::word_t    rdata2
);

    import rv32_isa_pkg::*;

    word_t regs [`RV32_NUM_REGS];

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

    // x0 is cleared by reset and never written
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RV32_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

endmodule

// File: src/rv32_word_ram.sv
`timescale 1ns/1ps

`include "rv32_params.svh"

module rv32_word_ram #(
    parameter type payload_t = logic [`RV32_XLEN-1:0],
    parameter int  DEPTH     = 32
) (
    input  logic                         clk,
    input  logic [`RV32_WORD_ADDR_W-1:0] addr,
    input  logic                         we,
    input  payload_t                     wdata,
    output payload_t                     rdata
);

    payload_t mem [DEPTH];

    // asynchronous read
    assign rdata = mem[addr];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // a write must land inside the array
    a_write_in_range: assert property (
        @(posedge clk)
        we |-> (addr < DEPTH) && !$isunknown(addr)
    ) else $error("ram write out of range, addr %0d depth %0d", addr, DEPTH);

endmodule

// File: src/rv32_core_pkg.sv
`include "rv32_params.svh"

package rv32_core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;
        logic    reg_write;
        logic    mem_write;
        logic    mem_to_reg;
        logic    halt;
    } ctrl_t;

    typedef enum logic [2:0] {
        HOST_LOAD_IMEM,
        HOST_WRITE_REG,
        HOST_READ_REG,
        HOST_WRITE_MEM,
        HOST_READ_MEM,
        HOST_START
    } host_op_t;

    typedef struct packed {
        host_op_t                      op;
        logic [`RV32_WORD_ADDR_W-1:0]  addr;
        rv32_isa_pkg::word_t           wdata;
    } host_cmd_t;

    // host side of the memory and register ports while halted
    typedef struct packed {
        logic                          imem_we;
        logic                          reg_we;
        logic                          dmem_we;
        logic [`RV32_WORD_ADDR_W-1:0]  idx;
        rv32_isa_pkg::word_t           wdata;
    } host_access_t;

endpackage

// File: src/rv32_isa_pkg.sv
`include "rv32_params.svh"

package rv32_isa_pkg;

    typedef logic [`RV32_XLEN-1:0] word_t;
    typedef logic [`RV32_REG_ADDR_W-1:0] reg_idx_t;

    // major opcodes of the kept subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_t;

    // shared by OP and OP_IMM
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_t;

    // bit of funct7 that picks sub and the arithmetic shifts
    localparam int unsigned FUNCT7_ALT_BIT = 5;

    // R-type layout; the other formats reuse the same bit positions
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } instr_t;

endpackage

// File: src/rv32_params.svh
`ifndef RV32_PARAMS_SVH
`define RV32_PARAMS_SVH

// data and instruction width
`define RV32_XLEN 32

// register file
`define RV32_REG_ADDR_W 5
`define RV32_NUM_REGS 32

// memory depths in words
`define RV32_IMEM_WORDS 32
`define RV32_DMEM_WORDS 32

// word index into either memory
`define RV32_WORD_ADDR_W 5

`endif
